// File: src/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // LRU scheme keeps one bit per set so the way count is fixed
    localparam int N_WAYS = 2;

    // Access width on master and slave buses
    typedef enum logic [1:0] {
        MASK_BYTE = 2'b00,
        MASK_HALF = 2'b01,
        MASK_WORD = 2'b10
    } mask_e;

    // One bus request
    // Held stable with en high until ack or err
    typedef struct packed {
        logic        en;
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
        mask_e       mask;
    } mem_req_t;

    // One bus response
    // Ack and err are single-cycle pulses
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: src/cache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module cache_tag_store #(
    parameter  int CAPACITY_BYTE = 8192,
    parameter  int BLOCK_BYTE    = 64,
    localparam int N_SETS        = CAPACITY_BYTE / BLOCK_BYTE / cache_pkg::N_WAYS,
    localparam int SET_W         = $clog2(N_SETS),
    localparam int TAG_W         = 32 - SET_W - $clog2(BLOCK_BYTE)
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    // Lookup address
    input  wire logic [SET_W-1:0] i_set,
    input  wire logic [TAG_W-1:0] i_tag,
    // Hit access update
    input  wire logic             i_touch,
    input  wire logic             i_touch_way,
    input  wire logic             i_touch_write,
    // Refill completion
    input  wire logic             i_fill,
    input  wire logic             i_fill_way,
    // Lookup result
    output logic                  o_hit,
    output logic                  o_hit_way,
    output logic                  o_lru_way,
    output logic                  o_victim_dirty,
    output logic [TAG_W-1:0]      o_victim_tag
);
    import cache_pkg::*;

    logic              valid [N_SETS][N_WAYS];
    logic              dirty [N_SETS][N_WAYS];
    logic [TAG_W-1:0]  tags  [N_SETS][N_WAYS];
    // Names the way to replace next
    logic              lru   [N_SETS];
    logic [N_WAYS-1:0] way_hit;

    // ========================================
    // Lookup
    // ========================================

    // Hit per way is valid and tag equal
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            way_hit[w] = valid[i_set][w] && (tags[i_set][w] == i_tag);
        end
    end

    assign o_hit          = |way_hit;
    assign o_hit_way      = way_hit[1];
    // Victim is always the LRU way of the set
    assign o_lru_way      = lru[i_set];
    assign o_victim_dirty = dirty[i_set][o_lru_way];
    assign o_victim_tag   = tags[i_set][o_lru_way];

    // ========================================
    // Update
    // ========================================

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            for (int s = 0; s < N_SETS; s++) begin
                lru[s] <= 1'b0;
                for (int w = 0; w < N_WAYS; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else if (i_fill) begin
            // Fresh block from memory is clean
            valid[i_set][i_fill_way] <= 1'b1;
            dirty[i_set][i_fill_way] <= 1'b0;
            lru[i_set]               <= !i_fill_way;
        end else if (i_touch) begin
            // Point away from the way just used
            lru[i_set] <= !i_touch_way;
            if (i_touch_write) begin
                dirty[i_set][i_touch_way] <= 1'b1;
            end
        end
    end

    // Tag written with the refilled block
    always_ff @(posedge i_clk) begin
        if (i_fill) begin
            tags[i_set][i_fill_way] <= i_tag;
        end
    end

    // Refill only targets a missing tag so one set never holds it twice
    a_one_way_hit: assert property (@(posedge i_clk) disable iff (!i_rst)
        $onehot0(way_hit));

endmodule

`default_nettype wire

// File: src/cache_data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module cache_data_ram #(
    parameter  int CAPACITY_BYTE = 8192,
    parameter  int BLOCK_BYTE    = 64,
    localparam int BLK_W         = $clog2(CAPACITY_BYTE / BLOCK_BYTE),
    localparam int OFF_W         = $clog2(BLOCK_BYTE),
    localparam int IDX_W         = BLK_W + OFF_W
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_en,
    input  wire logic             i_we,
    // Index is {set, way, byte offset}
    input  wire logic [IDX_W-1:0] i_index,
    input  wire logic [31:0]      i_wdata,
    input  wire cache_pkg::mask_e i_mask,
    output logic [31:0]           o_rdata,
    output logic                  o_ack
);
    import cache_pkg::*;

    localparam int N_WORDS = 2 ** (IDX_W - 2);

    // Both ways in one word-wide array
    logic [31:0]      mem [N_WORDS];
    logic [IDX_W-3:0] word;
    logic [3:0]       lane_en;

    assign word = i_index[IDX_W-1:2];

    // Byte lanes picked by width and low address bits
    always_comb begin
        case (i_mask)
            MASK_BYTE: lane_en = 4'b0001 << i_index[1:0];
            MASK_HALF: lane_en = i_index[1] ? 4'b1100 : 4'b0011;
            default:   lane_en = 4'b1111;
        endcase
    end

    // Write data already sits in its own lanes
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (lane_en[b]) begin
                        mem[word][8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
            end
            // Always the whole aligned word
            o_rdata <= mem[word];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_en;
        end
    end

    // Master alignment carried through the controller
    a_aligned: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_en |-> (i_mask == MASK_BYTE) ||
                 ((i_mask == MASK_HALF) && !i_index[0]) ||
                 ((i_mask == MASK_WORD) && (i_index[1:0] == 2'b00)));

endmodule

`default_nettype wire

// File: src/cache_controller.sv
`timescale 1ns/100ps
`default_nettype none

module cache_controller #(
    parameter  int CAPACITY_BYTE = 8192,
    parameter  int BLOCK_BYTE    = 64,
    localparam int OFF_W         = $clog2(BLOCK_BYTE),
    localparam int WORD_W        = OFF_W - 2,
    localparam int SET_W         = $clog2(CAPACITY_BYTE / BLOCK_BYTE / cache_pkg::N_WAYS),
    localparam int TAG_W         = 32 - SET_W - OFF_W,
    localparam int IDX_W         = SET_W + 1 + OFF_W
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    // Master and slave buses
    input  wire cache_pkg::mem_req_t i_m_req,
    output cache_pkg::mem_rsp_t      o_m_rsp,
    output cache_pkg::mem_req_t      o_s_req,
    input  wire cache_pkg::mem_rsp_t i_s_rsp,
    // Tag store
    output logic [SET_W-1:0]         o_set,
    output logic [TAG_W-1:0]         o_tag,
    output logic                     o_touch,
    output logic                     o_touch_way,
    output logic                     o_touch_write,
    output logic                     o_fill,
    output logic                     o_fill_way,
    input  wire logic                i_hit,
    input  wire logic                i_hit_way,
    input  wire logic                i_lru_way,
    input  wire logic                i_victim_dirty,
    input  wire logic [TAG_W-1:0]    i_victim_tag,
    // Data RAM
    output logic                     o_ram_en,
    output logic                     o_ram_we,
    output logic [IDX_W-1:0]         o_ram_index,
    output logic [31:0]              o_ram_wdata,
    output cache_pkg::mask_e         o_ram_mask,
    input  wire logic [31:0]         i_ram_rdata,
    input  wire logic                i_ram_ack
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HIT_ACC,
        ST_HIT_RSP,
        ST_EVICT_RD,
        ST_EVICT_WR,
        ST_REFILL_RD,
        ST_REFILL_WR,
        ST_ERR_RSP
    } state_e;

    state_e state;
    state_e state_nxt;

    // Latched request and lookup result
    mem_req_t req_q;
    logic     hit_q;
    logic     hit_way_q;
    logic     lru_way_q;
    logic     victim_dirty_q;

    logic [SET_W-1:0]  set_q;
    logic [TAG_W-1:0]  tag_q;
    // Word counter for write-back and refill
    logic [WORD_W-1:0] cnt;
    logic              cnt_last;
    logic              word_done;
    // RAM op already issued in this state
    logic              ram_sent;

    assign tag_q    = req_q.addr[31 -: TAG_W];
    assign set_q    = req_q.addr[OFF_W +: SET_W];
    assign cnt_last = &cnt;

    // ========================================
    // Tag store control
    // ========================================

    // Live address in idle, latched one afterwards
    assign o_set = (state == ST_IDLE) ? i_m_req.addr[OFF_W +: SET_W] : set_q;
    assign o_tag = (state == ST_IDLE) ? i_m_req.addr[31 -: TAG_W] : tag_q;

    // Touch once the hit access completes
    assign o_touch       = (state == ST_HIT_ACC) && i_ram_ack;
    assign o_touch_way   = hit_way_q;
    assign o_touch_write = req_q.we;
    // Fill with the last refilled word
    assign o_fill        = (state == ST_REFILL_WR) && i_ram_ack && cnt_last;
    assign o_fill_way    = lru_way_q;

    assign word_done = ((state == ST_EVICT_WR) && i_s_rsp.ack) ||
                       ((state == ST_REFILL_WR) && i_ram_ack);

    // ========================================
    // FSM
    // ========================================

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (i_m_req.en) begin
                    state_nxt = ST_HIT_ACC;
                end
            end
            ST_HIT_ACC: begin
                // Miss dispatches on the latched victim state
                if (!hit_q) begin
                    state_nxt = victim_dirty_q ? ST_EVICT_RD : ST_REFILL_RD;
                end else if (i_ram_ack) begin
                    state_nxt = ST_HIT_RSP;
                end
            end
            ST_EVICT_RD: begin
                if (i_ram_ack) begin
                    state_nxt = ST_EVICT_WR;
                end
            end
            ST_EVICT_WR: begin
                if (i_s_rsp.err) begin
                    state_nxt = ST_ERR_RSP;
                end else if (i_s_rsp.ack) begin
                    // Whole victim out before any refill read
                    state_nxt = cnt_last ? ST_REFILL_RD : ST_EVICT_RD;
                end
            end
            ST_REFILL_RD: begin
                if (i_s_rsp.err) begin
                    state_nxt = ST_ERR_RSP;
                end else if (i_s_rsp.ack) begin
                    state_nxt = ST_REFILL_WR;
                end
            end
            ST_REFILL_WR: begin
                // Finish as a hit on the filled way
                if (i_ram_ack) begin
                    state_nxt = cnt_last ? ST_HIT_ACC : ST_REFILL_RD;
                end
            end
            default: begin
                // Response pulse states
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state          <= ST_IDLE;
            ram_sent       <= 1'b0;
            cnt            <= '0;
            hit_q          <= 1'b0;
            victim_dirty_q <= 1'b0;
        end else begin
            state    <= state_nxt;
            ram_sent <= (state_nxt == state) && (ram_sent || o_ram_en);
            if ((state == ST_IDLE) && i_m_req.en) begin
                hit_q          <= i_hit;
                victim_dirty_q <= i_victim_dirty;
                cnt            <= '0;
            end
            if (o_fill) begin
                hit_q <= 1'b1;
            end
            // Wraps to zero after the last word
            if (word_done) begin
                cnt <= cnt + WORD_W'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if ((state == ST_IDLE) && i_m_req.en) begin
            req_q     <= i_m_req;
            hit_way_q <= i_hit_way;
            lru_way_q <= i_lru_way;
        end
        if (o_fill) begin
            hit_way_q <= lru_way_q;
        end
    end

    // ========================================
    // Data RAM and slave bus
    // ========================================

    always_comb begin
        o_ram_en    = 1'b0;
        o_ram_we    = 1'b0;
        o_ram_mask  = MASK_WORD;
        o_ram_wdata = i_s_rsp.data;
        // Block words of the victim way
        o_ram_index = {set_q, lru_way_q, cnt, 2'b00};
        case (state)
            ST_HIT_ACC: begin
                o_ram_en    = hit_q && !ram_sent;
                o_ram_we    = req_q.we;
                o_ram_mask  = req_q.mask;
                o_ram_wdata = req_q.data;
                o_ram_index = {set_q, hit_way_q, req_q.addr[OFF_W-1:0]};
            end
            ST_EVICT_RD: begin
                o_ram_en = !ram_sent;
            end
            ST_REFILL_RD: begin
                // Slave data is valid only with its ack
                o_ram_en = i_s_rsp.ack;
                o_ram_we = 1'b1;
            end
            default: begin
                o_ram_en = 1'b0;
            end
        endcase
    end

    // Slave request follows the state so it holds until ack
    always_comb begin
        o_s_req.en   = (state == ST_EVICT_WR) || (state == ST_REFILL_RD);
        o_s_req.we   = (state == ST_EVICT_WR);
        o_s_req.addr = {(state == ST_EVICT_WR) ? i_victim_tag : tag_q, set_q, cnt, 2'b00};
        // Victim word straight from the RAM output
        o_s_req.data = (state == ST_EVICT_WR) ? i_ram_rdata : 32'h0;
        o_s_req.mask = MASK_WORD;
    end

    // Master response, one-cycle pulses
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_m_rsp.ack <= 1'b0;
            o_m_rsp.err <= 1'b0;
        end else begin
            o_m_rsp.ack <= o_touch;
            o_m_rsp.err <= ((state == ST_EVICT_WR) || (state == ST_REFILL_RD)) && i_s_rsp.err;
        end
        if (o_touch) begin
            o_m_rsp.data <= i_ram_rdata;
        end
    end

    // Slave request holds while the bus stalls
    a_s_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst)
        o_s_req.en && !i_s_rsp.ack && !i_s_rsp.err |=> $stable(o_s_req));

endmodule

`default_nettype wire

// File: src/two_way_cache.sv
`timescale 1ns/100ps
`default_nettype none

module two_way_cache #(
    parameter int CAPACITY_BYTE = 8192,
    parameter int BLOCK_BYTE    = 64
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    input  wire cache_pkg::mem_req_t i_m_req,
    output cache_pkg::mem_rsp_t      o_m_rsp,
    output cache_pkg::mem_req_t      o_s_req,
    input  wire cache_pkg::mem_rsp_t i_s_rsp
);
    import cache_pkg::*;

    localparam int OFF_W = $clog2(BLOCK_BYTE);
    localparam int SET_W = $clog2(CAPACITY_BYTE / BLOCK_BYTE / N_WAYS);
    localparam int TAG_W = 32 - SET_W - OFF_W;
    localparam int IDX_W = SET_W + 1 + OFF_W;

    // Tag store lookup and update
    logic [SET_W-1:0] set;
    logic [TAG_W-1:0] tag;
    logic             touch;
    logic             touch_way;
    logic             touch_write;
    logic             fill;
    logic             fill_way;
    logic             hit;
    logic             hit_way;
    logic             lru_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;

    // Data RAM port
    logic             ram_en;
    logic             ram_we;
    logic [IDX_W-1:0] ram_index;
    logic [31:0]      ram_wdata;
    mask_e            ram_mask;
    logic [31:0]      ram_rdata;
    logic             ram_ack;

    cache_controller #(
        .CAPACITY_BYTE (CAPACITY_BYTE),
        .BLOCK_BYTE    (BLOCK_BYTE)
    ) u_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_m_req        (i_m_req),
        .o_m_rsp        (o_m_rsp),
        .o_s_req        (o_s_req),
        .i_s_rsp        (i_s_rsp),
        .o_set          (set),
        .o_tag          (tag),
        .o_touch        (touch),
        .o_touch_way    (touch_way),
        .o_touch_write  (touch_write),
        .o_fill         (fill),
        .o_fill_way     (fill_way),
        .i_hit          (hit),
        .i_hit_way      (hit_way),
        .i_lru_way      (lru_way),
        .i_victim_dirty (victim_dirty),
        .i_victim_tag   (victim_tag),
        .o_ram_en       (ram_en),
        .o_ram_we       (ram_we),
        .o_ram_index    (ram_index),
        .o_ram_wdata    (ram_wdata),
        .o_ram_mask     (ram_mask),
        .i_ram_rdata    (ram_rdata),
        .i_ram_ack      (ram_ack)
    );

    cache_tag_store #(
        .CAPACITY_BYTE (CAPACITY_BYTE),
        .BLOCK_BYTE    (BLOCK_BYTE)
    ) u_tags (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_set          (set),
        .i_tag          (tag),
        .i_touch        (touch),
        .i_touch_way    (touch_way),
        .i_touch_write  (touch_write),
        .i_fill         (fill),
        .i_fill_way     (fill_way),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_lru_way      (lru_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag)
    );

    cache_data_ram #(
        .CAPACITY_BYTE (CAPACITY_BYTE),
        .BLOCK_BYTE    (BLOCK_BYTE)
    ) u_ram (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_index (ram_index),
        .i_wdata (ram_wdata),
        .i_mask  (ram_mask),
        .o_rdata (ram_rdata),
        .o_ack   (ram_ack)
    );

endmodule

`default_nettype wire

// File: tb/cache_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cache_checker #(
    parameter int CAPACITY_BYTE = 8192,
    parameter int BLOCK_BYTE    = 64
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst,
    // Both DUT buses, watched only
    input  wire cache_pkg::mem_req_t i_m_req,
    input  wire cache_pkg::mem_rsp_t i_m_rsp,
    input  wire cache_pkg::mem_req_t i_s_req,
    input  wire cache_pkg::mem_rsp_t i_s_rsp,
    // Expected outcome of the current row
    input  wire logic                i_exp_miss,
    input  wire logic                i_exp_err,
    output int                       o_errors,
    output int                       o_checks,
    output int                       o_rows
);
    import cache_pkg::*;

    localparam int          N_WORDS  = BLOCK_BYTE / 4;
    localparam logic [31:0] BLK_MASK = 32'(BLOCK_BYTE - 1);
    // Set bits sit between block offset and tag
    localparam logic [31:0] SET_MASK = 32'(CAPACITY_BYTE / N_WAYS - 1) & ~BLK_MASK;
    // Issue, RAM ack, registered response
    localparam int          HIT_CYCLES = 3;

    // Shadow of slave memory, keyed by word address
    logic [31:0] shadow [logic [31:0]];
    mem_req_t    req_q;
    logic        busy         = 1'b0;
    logic        exp_miss_q   = 1'b0;
    logic        exp_err_q    = 1'b0;
    logic        prev_rst_low = 1'b0;
    int          n_rd         = 0;
    int          n_wr         = 0;
    int          n_cyc        = 0;
    int          errors       = 0;
    int          checks       = 0;
    int          rows         = 0;

    assign o_errors = errors;
    assign o_checks = checks;
    assign o_rows   = rows;

    // Unwritten words hold their own address scrambled
    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:2], 2'b00};
        if (shadow.exists(word_addr)) begin
            return shadow[word_addr];
        end
        return word_addr ^ 32'hA5A5_0000;
    endfunction

    // Bits of the word touched by one write
    function automatic logic [31:0] lane_bits(input mask_e mask, input logic [1:0] low);
        case (mask)
            MASK_BYTE: return 32'h0000_00FF << (8 * low);
            MASK_HALF: return low[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
            default:   return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ========================================
    // End of one master access
    // ========================================

    task automatic finish_row();
        logic [31:0] lanes;
        logic [31:0] word_addr;
        rows++;
        check_flag("o_m_rsp.err", i_m_rsp.err, exp_err_q);
        check_flag("o_m_rsp.ack", i_m_rsp.ack, !exp_err_q);
        // Any slave read means the block was missing
        check_flag("miss", n_rd != 0, exp_miss_q);
        if (i_m_rsp.ack) begin
            if (n_rd == 0) begin
                // Hit stays off the slave bus with fixed latency
                check_value("slave write count", n_wr, 32'h0);
                check_value("hit latency", n_cyc, HIT_CYCLES);
            end else begin
                check_value("slave read count", n_rd, N_WORDS);
                if (n_wr != 0) begin
                    check_value("slave write count", n_wr, N_WORDS);
                end
            end
            if (req_q.we) begin
                lanes     = lane_bits(req_q.mask, req_q.addr[1:0]);
                word_addr = {req_q.addr[31:2], 2'b00};
                shadow[word_addr] = (shadow_word(word_addr) & ~lanes) | (req_q.data & lanes);
            end else begin
                check_value("o_m_rsp.data", i_m_rsp.data, shadow_word(req_q.addr));
            end
        end
    endtask

    // ========================================
    // Sampling at the DUT clock edge
    // ========================================

    always @(posedge i_clk) begin
        // Idle outputs through reset and one cycle beyond
        if (prev_rst_low) begin
            check_flag("o_m_rsp.ack", i_m_rsp.ack, 1'b0);
            check_flag("o_m_rsp.err", i_m_rsp.err, 1'b0);
            check_flag("o_s_req.en", i_s_req.en, 1'b0);
        end
        prev_rst_low = !i_rst;
        if (!i_rst) begin
            busy = 1'b0;
        end else if (busy) begin
            n_cyc++;
            if (i_s_req.en && (i_s_rsp.ack || i_s_rsp.err)) begin
                // Every slave beat is a whole word
                check_value("o_s_req.mask", {30'h0, i_s_req.mask}, {30'h0, MASK_WORD});
                if (i_s_req.we) begin
                    // Victim words in order, same set, current contents
                    check_value("o_s_req.addr offset", i_s_req.addr & BLK_MASK, n_wr * 4);
                    check_value("o_s_req.addr set", (i_s_req.addr ^ req_q.addr) & SET_MASK,
                                32'h0);
                    check_value("o_s_req.data", i_s_req.data, shadow_word(i_s_req.addr));
                    n_wr++;
                end else begin
                    // Refill from word 0 of the requested block
                    check_value("o_s_req.addr", i_s_req.addr,
                                (req_q.addr & ~BLK_MASK) + 32'(n_rd * 4));
                    n_rd++;
                end
            end
            if (i_m_rsp.ack || i_m_rsp.err) begin
                finish_row();
                busy = 1'b0;
            end
        end else begin
            // Quiet buses between accesses
            check_flag("o_m_rsp.ack", i_m_rsp.ack, 1'b0);
            check_flag("o_m_rsp.err", i_m_rsp.err, 1'b0);
            check_flag("o_s_req.en", i_s_req.en, 1'b0);
            if (i_m_req.en) begin
                busy       = 1'b1;
                req_q      = i_m_req;
                exp_miss_q = i_exp_miss;
                exp_err_q  = i_exp_err;
                n_rd       = 0;
                n_wr       = 0;
                n_cyc      = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_two_way_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_two_way_cache;
    import cache_pkg::*;

    localparam int          CAPACITY_BYTE = 8192;
    localparam int          BLOCK_BYTE    = 64;
    localparam int          RSP_TIMEOUT   = 1000;
    localparam logic [31:0] SEED          = 32'h7302a8bd;

    // One stimulus row with its expected outcome
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
        mask_e       mask;
        logic        exp_miss;
        logic        exp_err;
    } row_t;

    logic     clk = 1'b0;
    logic     rst;
    mem_req_t m_req;
    mem_rsp_t m_rsp;
    mem_req_t s_req;
    mem_rsp_t s_rsp;
    logic     exp_miss;
    logic     exp_err;
    logic     timed_out = 1'b0;
    int       errors;
    int       checks;
    int       rows_done;
    row_t     rows [$];

    // Slave memory, keyed by word address
    logic [31:0] slave_mem [logic [31:0]];

    always #4 clk = !clk;

    two_way_cache #(
        .CAPACITY_BYTE (CAPACITY_BYTE),
        .BLOCK_BYTE    (BLOCK_BYTE)
    ) UUT (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_m_req (m_req),
        .o_m_rsp (m_rsp),
        .o_s_req (s_req),
        .i_s_rsp (s_rsp)
    );

    cache_checker #(
        .CAPACITY_BYTE (CAPACITY_BYTE),
        .BLOCK_BYTE    (BLOCK_BYTE)
    ) u_checker (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_m_req    (m_req),
        .i_m_rsp    (m_rsp),
        .i_s_req    (s_req),
        .i_s_rsp    (s_rsp),
        .i_exp_miss (exp_miss),
        .i_exp_err  (exp_err),
        .o_errors   (errors),
        .o_checks   (checks),
        .o_rows     (rows_done)
    );

    // ========================================
    // Slave memory model
    // ========================================

    initial begin : slave_model
        int          delay;
        logic [31:0] word_addr;
        s_rsp = '0;
        forever begin
            @(negedge clk);
            s_rsp.ack = 1'b0;
            s_rsp.err = 1'b0;
            if (rst && s_req.en) begin
                // Random stall of 1 to 4 cycles
                delay = 1 + int'($urandom % 4);
                repeat (delay - 1) @(negedge clk);
                word_addr = {s_req.addr[31:2], 2'b00};
                if (s_req.addr[31:28] == 4'hF) begin
                    s_rsp.err = 1'b1;
                end else if (s_req.we) begin
                    slave_mem[word_addr] = s_req.data;
                    s_rsp.ack = 1'b1;
                end else begin
                    s_rsp.data = slave_mem.exists(word_addr) ? slave_mem[word_addr]
                                                             : word_addr ^ 32'hA5A5_0000;
                    s_rsp.ack  = 1'b1;
                end
            end
        end
    end

    // ========================================
    // Stimulus table
    // ========================================

    task automatic add_row(input logic we, input logic [31:0] addr, input logic [31:0] data,
                           input mask_e mask, input logic miss, input logic err);
        row_t r;
        r.we       = we;
        r.addr     = addr;
        r.data     = data;
        r.mask     = mask;
        r.exp_miss = miss;
        r.exp_err  = err;
        rows.push_back(r);
    endtask

    task automatic load_table();
        // Cold read then hit, set 1
        add_row(1'b0, 32'h0000_1040, 32'h0, MASK_WORD, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_1044, 32'h0, MASK_WORD, 1'b0, 1'b0);
        // Word, byte and halfword merged in one word
        add_row(1'b1, 32'h0000_1048, 32'h1122_3344, MASK_WORD, 1'b0, 1'b0);
        add_row(1'b1, 32'h0000_1049, 32'h0000_AA00, MASK_BYTE, 1'b0, 1'b0);
        add_row(1'b1, 32'h0000_104A, 32'hBBCC_0000, MASK_HALF, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_1048, 32'h0, MASK_WORD, 1'b0, 1'b0);
        // LRU in set 3: A, B, A, then C replaces B
        add_row(1'b0, 32'h0000_20C0, 32'h0, MASK_WORD, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_50C0, 32'h0, MASK_WORD, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_20C4, 32'h0, MASK_WORD, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_90C0, 32'h0, MASK_WORD, 1'b1, 1'b0);
        add_row(1'b0, 32'h0000_20C8, 32'h0, MASK_WORD, 1'b0, 1'b0);
        add_row(1'b0, 32'h0000_50C0, 32'h0, MASK_WORD, 1'b1, 1'b0);
        // Dirty block in set 5 pushed out and read back
        add_row(1'b1, 32'h0001_1140, 32'hDEAD_BEEF, MASK_WORD, 1'b1, 1'b0);
        add_row(1'b1, 32'h0001_117C, 32'h1234_5678, MASK_WORD, 1'b0, 1'b0);
        add_row(1'b0, 32'h0001_2140, 32'h0, MASK_WORD, 1'b1, 1'b0);
        add_row(1'b0, 32'h0001_3140, 32'h0, MASK_WORD, 1'b1, 1'b0);
        add_row(1'b0, 32'h0001_1140, 32'h0, MASK_WORD, 1'b1, 1'b0);
        add_row(1'b0, 32'h0001_117C, 32'h0, MASK_WORD, 1'b0, 1'b0);
        // Bus errors, each followed by a normal access
        add_row(1'b0, 32'hF000_0200, 32'h0, MASK_WORD, 1'b1, 1'b1);
        add_row(1'b0, 32'h0000_1040, 32'h0, MASK_WORD, 1'b0, 1'b0);
        add_row(1'b1, 32'hF000_0301, 32'h0000_7700, MASK_BYTE, 1'b1, 1'b1);
        add_row(1'b0, 32'h0000_20C0, 32'h0, MASK_WORD, 1'b0, 1'b0);
    endtask

    // ========================================
    // Master driver
    // ========================================

    task automatic apply_row(input row_t r);
        int waited;
        @(negedge clk);
        m_req.en   = 1'b1;
        m_req.we   = r.we;
        m_req.addr = r.addr;
        m_req.data = r.data;
        m_req.mask = r.mask;
        exp_miss   = r.exp_miss;
        exp_err    = r.exp_err;
        waited     = 0;
        @(negedge clk);
        while (!(m_rsp.ack || m_rsp.err) && (waited < RSP_TIMEOUT)) begin
            @(negedge clk);
            waited++;
        end
        if (!(m_rsp.ack || m_rsp.err)) begin
            $display("Timeout: no response from the cache for address %h", r.addr);
            timed_out = 1'b1;
        end
        // Request drops once the response is seen
        m_req.en = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        rst      = 1'b0;
        m_req    = '0;
        exp_miss = 1'b0;
        exp_err  = 1'b0;
        load_table();
        repeat (2) @(negedge clk);
        rst = 1'b1;
        for (int i = 0; (i < rows.size()) && !timed_out; i++) begin
            apply_row(rows[i]);
        end
        // Checker retires the last row
        repeat (3) @(negedge clk);
        $display("Rows %0d of %0d, checks %0d, errors %0d", rows_done, rows.size(), checks,
                 errors);
        if (rows_done != rows.size()) begin
            $display("Not every table row received a response");
        end
        if ((errors == 0) && !timed_out && (rows_done == rows.size())) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/cache_pkg.sv
src/cache_tag_store.sv
src/cache_data_ram.sv
src/cache_controller.sv
src/two_way_cache.sv
tb/cache_checker.sv
tb/tb_two_way_cache.sv

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_two_way_cache \
    -o tb_two_way_cache

./obj_dir/tb_two_way_cache | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
